// File: Makefile
SRCS = nd_cpu_pkg.sv nd_apb_pkg.sv cs_if.sv wcs_apb_port.sv control_store.sv \
       micro_seq.sv cpu_out_stage.sv cpu_top.sv tb_cpu_top.sv

.PHONY: run clean

obj_dir/Vtb_cpu_top: filelist.f $(SRCS)
	verilator --binary --timing --assert -f filelist.f --top-module tb_cpu_top -o Vtb_cpu_top

run: obj_dir/Vtb_cpu_top
	./obj_dir/Vtb_cpu_top > sim.log; cat sim.log
	! grep -q "SIMULATION FAILED" sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: control_store.sv
// ==========================================================
// Writable control store, 256 x 64, half-word host writes,
// one synchronous read port and IDB readback driver
// ==========================================================
`timescale 1ns/1ps

module control_store
  import nd_cpu_pkg::*;
(
  input  logic                 sysclk,
  input  logic                 rst_n,
  cs_if.store                  cs,
  output logic [bus_width-1:0] cs_idb   // Zero unless a host readback
);

  logic [mw_width-1:0] mem [cs_depth];
  logic [cs_aw-1:0]    rd_addr;
  logic                host_rd_q;       // rdata holds a host read

  // Host has priority on the shared read port
  assign rd_addr = cs.host_re ? cs.host_addr : cs.seq_addr;

  always_ff @(posedge sysclk) begin
    if (cs.host_we) begin
      if (cs.host_hi) begin
        mem[cs.host_addr][mw_width-1:hw_width] <= cs.host_wdata;  // Upper half only
      end else begin
        mem[cs.host_addr][hw_width-1:0] <= cs.host_wdata;
      end
    end
    if (cs.host_re | cs.seq_re) begin
      cs.rdata <= microword_t'(mem[rd_addr]);
    end
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      host_rd_q <= 1'b0;
    end else begin
      host_rd_q <= cs.host_re;
    end
  end

  // Console fetch puts the low word bits on IDB for one cycle
  assign cs_idb = host_rd_q ? cs.rdata[bus_width-1:0] : '0;

endmodule

// File: cpu_out_stage.sv
// ==========================================================
// Output stage: CD bus register, test port mux, run LED
// ==========================================================
`timescale 1ns/1ps

module cpu_out_stage
  import nd_cpu_pkg::*;
(
  input  logic                 sysclk,
  input  logic                 rst_n,
  input  logic [bus_width-1:0] idb,
  input  logic                 out_valid,
  input  logic [cs_aw-1:0]     upc,
  input  logic                 zero,
  input  logic                 running,
  input  logic [2:0]           sel_testmux,
  output logic [bus_width-1:0] cd_out,
  output logic                 cd_valid,    // One pulse per value
  output logic [4:0]           test,
  output logic                 led
);

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      cd_out   <= '0;
      cd_valid <= 1'b0;
      led      <= 1'b0;
    end else begin
      cd_valid <= out_valid;
      if (out_valid) cd_out <= idb;  // Holds last value between events
      led <= running;
    end
  end

  // Test port selection
  always_comb begin
    case (sel_testmux)
      3'd0:    test = upc[4:0];
      3'd1:    test = upc[7:3];
      3'd2:    test = {zero, running, 3'b000};
      3'd3:    test = cd_out[4:0];
      default: test = '0;
    endcase
  end

endmodule

// File: cpu_top.sv
// ==========================================================
// CPU board top: host port, control store, sequencer and
// output stage around the OR-ed IDB
// ==========================================================
`timescale 1ns/1ps

module cpu_top
  import nd_cpu_pkg::*;
  import nd_apb_pkg::*;
(
  input  logic                 sysclk,
  input  logic                 rst_n,
  input  logic [apb_aw-1:0]    paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [apb_dw-1:0]    pwdata,
  output logic [apb_dw-1:0]    prdata,
  output logic                 pready,
  output logic                 pslverr,
  input  logic [2:0]           sel_testmux,
  output logic [bus_width-1:0] cd_out,
  output logic                 cd_valid,
  output logic [4:0]           test,
  output logic                 led
);

  logic [bus_width-1:0] seq_idb;
  logic [bus_width-1:0] cs_idb;
  logic [bus_width-1:0] idb;
  logic [cs_aw-1:0]     upc;
  logic                 start;
  logic                 running;
  logic                 halted;
  logic                 zero;
  logic                 out_valid;

  cs_if cs_bus ();

  // Each driver is zero when idle, so OR forms the bus
  assign idb = seq_idb | cs_idb;

  wcs_apb_port wcs_port (
    .sysclk (sysclk), .rst_n (rst_n), .paddr (paddr), .psel (psel),
    .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
    .pready (pready), .pslverr(pslverr), .upc(upc), .running(running),
    .halted (halted), .start(start), .cs(cs_bus.host)
  );

  control_store cstore (.sysclk(sysclk), .rst_n(rst_n), .cs(cs_bus.store), .cs_idb(cs_idb));

  micro_seq seq (
    .sysclk (sysclk), .rst_n(rst_n), .start(start), .cs(cs_bus.seq),
    .seq_idb(seq_idb), .out_valid(out_valid), .upc(upc), .running(running),
    .halted (halted), .zero(zero)
  );

  cpu_out_stage out_stage (
    .sysclk(sysclk), .rst_n(rst_n), .idb(idb), .out_valid(out_valid), .upc(upc),
    .zero  (zero), .running(running), .sel_testmux(sel_testmux), .cd_out(cd_out),
    .cd_valid(cd_valid), .test(test), .led(led)
  );

endmodule

// File: cs_if.sv
// ==========================================================
// Control store access bundle for host port and sequencer
// ==========================================================
`timescale 1ns/1ps

interface cs_if
  import nd_cpu_pkg::*;
();

  // Host side, only while the sequencer is stopped
  logic [cs_aw-1:0]    host_addr;
  logic [hw_width-1:0] host_wdata;
  logic                host_we;
  logic                host_hi;    // Upper half select
  logic                host_re;

  // Sequencer fetch
  logic [cs_aw-1:0]    seq_addr;
  logic                seq_re;

  microword_t          rdata;      // Valid the cycle after a read

  modport host  (output host_addr, host_wdata, host_we, host_hi, host_re, input rdata);
  modport seq   (output seq_addr, seq_re, input rdata);
  modport store (input host_addr, host_wdata, host_we, host_hi, host_re,
                 input seq_addr, seq_re, output rdata);

endinterface

// File: filelist.f
nd_cpu_pkg.sv
nd_apb_pkg.sv
cs_if.sv
wcs_apb_port.sv
control_store.sv
micro_seq.sv
cpu_out_stage.sv
cpu_top.sv
tb_cpu_top.sv

// File: micro_seq.sv
// ==========================================================
// Microsequencer: fetch/execute FSM, register file, ALU,
// zero flag, branch and halt
// ==========================================================
`timescale 1ns/1ps

module micro_seq
  import nd_cpu_pkg::*;
(
  input  logic                 sysclk,
  input  logic                 rst_n,
  input  logic                 start,
  cs_if.seq                    cs,
  output logic [bus_width-1:0] seq_idb,    // IDB driver, zero when idle
  output logic                 out_valid,
  output logic [cs_aw-1:0]     upc,
  output logic                 running,
  output logic                 halted,
  output logic                 zero
);

  typedef enum logic [1:0] {st_idle, st_fetch, st_exec} state_t;

  state_t               state;
  microword_t           mw;
  logic [bus_width-1:0] rf [reg_count];
  logic [bus_width-1:0] opa;
  logic [bus_width-1:0] opb;
  logic [bus_width-1:0] res;      // ALU result
  logic                 wr_en;    // Op writes dst and zero
  logic                 take_br;

  assign mw      = cs.rdata;      // Word fetched last cycle
  assign opa     = rf[mw.srca];
  assign opb     = rf[mw.srcb];
  assign take_br = (mw.opcode == op_brz) & zero;

  assign cs.seq_addr = upc;
  assign cs.seq_re   = (state == st_fetch);

  always_comb begin
    res   = '0;
    wr_en = 1'b1;
    case (mw.opcode)
      op_ldi:  res = mw.imm;
      op_add:  res = opa + opb;
      op_sub:  res = opa - opb;
      op_and:  res = opa & opb;
      op_or:   res = opa | opb;
      op_xor:  res = opa ^ opb;
      default: wr_en = 1'b0;  // nop, out, brz, hlt
    endcase
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      upc       <= '0;
      running   <= 1'b0;
      halted    <= 1'b0;
      zero      <= 1'b0;
      out_valid <= 1'b0;
      seq_idb   <= '0;
    end else begin
      out_valid <= 1'b0;
      seq_idb   <= '0;  // Bus released by default
      if (start) begin
        state   <= st_fetch;  // Restart at word 0
        upc     <= '0;
        running <= 1'b1;
        halted  <= 1'b0;
        zero    <= 1'b0;
      end else begin
        case (state)
          st_fetch: state <= st_exec;
          st_exec: begin
            if (mw.opcode == op_hlt) begin
              state   <= st_idle;  // upc stays on the halt word
              running <= 1'b0;
              halted  <= 1'b1;
            end else begin
              state <= st_fetch;
              upc   <= take_br ? mw.imm[cs_aw-1:0] : mw.next;
            end
            if (wr_en) zero <= (res == '0);
            if (mw.opcode == op_out) begin
              seq_idb   <= opa;
              out_valid <= 1'b1;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // Register file, cleared on start
  always_ff @(posedge sysclk) begin
    if (start) begin
      for (int i = 0; i < int'(reg_count); i++) begin
        rf[i] <= '0;
      end
    end else if ((state == st_exec) && wr_en) begin
      rf[mw.dst] <= res;
    end
  end

endmodule

// File: nd_apb_pkg.sv
// ==========================================================
// Host port definitions: APB widths, address map and
// register bit positions
// ==========================================================
package nd_apb_pkg;

  localparam int unsigned apb_aw = 12;  // Byte address width
  localparam int unsigned apb_dw = 32;

  // Control store window, two 32-bit halves per word
  localparam logic [apb_aw-1:0] cs_base = 12'h000;
  localparam logic [apb_aw-1:0] cs_last = 12'h7FF;
  localparam int unsigned cs_idx_lsb    = 3;  // Word index is paddr[10:3]
  localparam int unsigned cs_hi_bit     = 2;  // 1 = upper half

  // Run control, write 1 to start at micro address 0
  localparam logic [apb_aw-1:0] ctrl_addr = 12'h800;
  localparam int unsigned ctrl_run_bit    = 0;

  // Status, read only
  //   [7:0] upc, [8] running, [9] halted
  localparam logic [apb_aw-1:0] stat_addr = 12'h804;

endpackage

// File: nd_cpu_pkg.sv
// ==========================================================
// Core definitions: microword layout, opcode encoding,
// control-store and register file sizes
// ==========================================================
package nd_cpu_pkg;

  localparam int unsigned cs_depth  = 256;           // Control store words
  localparam int unsigned cs_aw     = 8;             // Micro address width
  localparam int unsigned mw_width  = 64;            // Microword width
  localparam int unsigned hw_width  = mw_width / 2;  // Host write half
  localparam int unsigned reg_count = 8;
  localparam int unsigned reg_aw    = 3;             // Register index width
  localparam int unsigned bus_width = 16;            // IDB and CD width

  // Microcode operations
  typedef enum logic [3:0] {
    op_nop = 4'h0,
    op_ldi = 4'h1,  // dst = imm
    op_add = 4'h2,
    op_sub = 4'h3,
    op_and = 4'h4,
    op_or  = 4'h5,
    op_xor = 4'h6,
    op_out = 4'h7,  // srca onto IDB
    op_brz = 4'h8,  // Branch to imm[7:0] on zero
    op_hlt = 4'h9
  } opcode_t;

  // Opcode sits in the low bits, spare bits on top
  typedef struct packed {
    logic [26:0]          spare;
    logic [cs_aw-1:0]     next;   // Default successor
    logic [bus_width-1:0] imm;
    logic [reg_aw-1:0]    srcb;
    logic [reg_aw-1:0]    srca;
    logic [reg_aw-1:0]    dst;
    opcode_t              opcode;
  } microword_t;

endpackage

// File: tb_cpu_top.sv
// ==========================================================
// Testbench for cpu_top with APB driver, xorshift program
// generator, microcode reference model and output monitor
// ==========================================================
`timescale 1ns/1ps

module tb_cpu_top
  import nd_cpu_pkg::*;
  import nd_apb_pkg::*;
();

  logic                 sysclk;
  logic                 rst_n;
  logic [apb_aw-1:0]    paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [apb_dw-1:0]    pwdata;
  logic [apb_dw-1:0]    prdata;
  logic                 pready;
  logic                 pslverr;
  logic [2:0]           sel_testmux;
  logic [bus_width-1:0] cd_out;
  logic                 cd_valid;
  logic [4:0]           test;
  logic                 led;

  int                   errors;
  int                   checks;
  logic [31:0]          rng_state = 32'hc084afed;
  logic [mw_width-1:0]  cs_model [cs_depth];  // Mirror of the store contents
  logic [bus_width-1:0] exp_q [$];            // Model output sequence
  logic [bus_width-1:0] got_q [$];            // Seen on cd_out
  logic                 model_zero;           // Zero flag at the last halt

  cpu_top dut (.*);

  initial begin
    sysclk = 1'b0;
    forever #10 sysclk = ~sysclk;
  end

  // One entry per cd_valid pulse
  always @(negedge sysclk) begin
    if (cd_valid) got_q.push_back(cd_out);
  end

  function automatic logic [31:0] xorshift32();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("error %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    errors++;
    $display("%s", why);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  // Setup phase, access phase, then wait for pready
  task automatic apb_xfer(input logic wr, input logic [apb_aw-1:0] addr,
                          input logic [apb_dw-1:0] wdata,
                          output logic [apb_dw-1:0] rdata, output logic err);
    int waits;
    waits = 0;
    @(posedge sysclk); #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge sysclk); #2;
    penable = 1'b1;
    @(negedge sysclk);
    while (!pready && waits < 8) begin
      @(negedge sysclk);
      waits++;
    end
    if (!pready) abort_run("APB transfer never completed, pready stuck low");
    rdata = prdata;
    err   = pslverr;
    @(posedge sysclk); #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic load_word(input logic [cs_aw-1:0] addr, input logic [mw_width-1:0] word);
    logic [apb_dw-1:0] rd;
    logic              err;
    apb_xfer(1'b1, {1'b0, addr, 3'b000}, word[31:0], rd, err);
    check_value("load low pslverr", 64'(0), 64'(err));
    apb_xfer(1'b1, {1'b0, addr, 3'b100}, word[63:32], rd, err);
    check_value("load high pslverr", 64'(0), 64'(err));
    cs_model[addr] = word;
  endtask

  task automatic verify_word(input logic [cs_aw-1:0] addr, input string name);
    logic [apb_dw-1:0] lo;
    logic [apb_dw-1:0] hi;
    logic              err_lo;
    logic              err_hi;
    apb_xfer(1'b0, {1'b0, addr, 3'b000}, 32'h0, lo, err_lo);
    apb_xfer(1'b0, {1'b0, addr, 3'b100}, 32'h0, hi, err_hi);
    check_value(name, cs_model[addr], {hi, lo});
    check_value({name, " pslverr"}, 64'(0), 64'(err_lo | err_hi));
  endtask

  // Poll status until the halted bit shows
  task automatic wait_halt(output logic [apb_dw-1:0] st);
    int   polls;
    logic err;
    polls = 0;
    apb_xfer(1'b0, stat_addr, 32'h0, st, err);
    while (!st[9] && polls < 300) begin
      apb_xfer(1'b0, stat_addr, 32'h0, st, err);
      polls++;
    end
    if (!st[9]) abort_run("program did not halt within the poll limit");
  endtask

  function automatic logic [mw_width-1:0] make_word(input opcode_t op, input logic [2:0] dst,
      input logic [2:0] srca, input logic [2:0] srcb, input logic [15:0] imm,
      input logic [7:0] nxt);
    microword_t w;
    w.spare  = 27'(xorshift32());  // Spare bits must be ignored
    w.next   = nxt;
    w.imm    = imm;
    w.srcb   = srcb;
    w.srca   = srca;
    w.dst    = dst;
    w.opcode = op;
    return w;
  endfunction

  // Reference interpreter from word 0 to the halt
  function automatic void run_model(output logic [cs_aw-1:0] halt_pc, output logic zero_f);
    logic [bus_width-1:0] rf [reg_count];
    microword_t           w;
    logic [bus_width-1:0] r;
    logic [cs_aw-1:0]     pc;
    logic [cs_aw-1:0]     nxt;
    logic                 z;
    logic                 wr;
    logic                 done;
    int                   steps;
    for (int i = 0; i < int'(reg_count); i++) rf[i] = '0;  // Cleared by start
    pc    = '0;
    z     = 1'b0;
    done  = 1'b0;
    steps = 0;
    exp_q.delete();
    while (!done && steps < 2000) begin
      w   = microword_t'(cs_model[pc]);
      nxt = w.next;
      wr  = 1'b1;
      r   = '0;
      case (w.opcode)
        op_ldi: r = w.imm;
        op_add: r = rf[w.srca] + rf[w.srcb];
        op_sub: r = rf[w.srca] - rf[w.srcb];
        op_and: r = rf[w.srca] & rf[w.srcb];
        op_or:  r = rf[w.srca] | rf[w.srcb];
        op_xor: r = rf[w.srca] ^ rf[w.srcb];
        op_out: begin
          wr = 1'b0;
          exp_q.push_back(rf[w.srca]);
        end
        op_brz: begin
          wr = 1'b0;
          if (z) nxt = w.imm[cs_aw-1:0];
        end
        op_hlt: begin
          wr   = 1'b0;
          done = 1'b1;
        end
        default: wr = 1'b0;
      endcase
      if (wr) begin
        rf[w.dst] = r;
        z = (r == '0);
      end
      if (!done) pc = nxt;
      steps++;
    end
    halt_pc = pc;
    zero_f  = z;
  endfunction

  // Start the program, optionally poke the locked store, then compare outputs
  task automatic run_and_check(input string name, input logic probe);
    logic [cs_aw-1:0]  hpc;
    logic [apb_dw-1:0] st;
    logic [apb_dw-1:0] rd;
    logic              err;
    run_model(hpc, model_zero);
    got_q.delete();
    apb_xfer(1'b1, ctrl_addr, 32'h1, rd, err);
    check_value({name, " run pslverr"}, 64'(0), 64'(err));
    if (probe) begin
      apb_xfer(1'b1, {1'b0, 8'hff, 3'b000}, ~cs_model[255][31:0], rd, err);
      check_value("locked write pslverr", 64'(1), 64'(err));
      apb_xfer(1'b0, {1'b0, 8'hff, 3'b100}, 32'h0, rd, err);
      check_value("locked read pslverr", 64'(1), 64'(err));
      check_value("led while running", 64'(1), 64'(led));
    end
    wait_halt(st);
    check_value({name, " halt upc"}, 64'(hpc), 64'(st[7:0]));
    check_value({name, " running"}, 64'(0), 64'(st[8]));
    check_value("led after halt", 64'(0), 64'(led));
    check_value({name, " out count"}, 64'(exp_q.size()), 64'(got_q.size()));
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_value($sformatf("%s out %0d", name, i), 64'(exp_q[i]), 64'(got_q[i]));
    end
  endtask

  // Chained random program ending in a halt
  task automatic gen_program();
    logic [cs_aw-1:0] pc;
    logic [cs_aw-1:0] nxt;
    logic [31:0]      r;
    logic [31:0]      r2;
    opcode_t          op;
    pc = '0;
    for (int k = 0; k < 24; k++) begin
      r   = xorshift32();
      r2  = xorshift32();
      nxt = pc + 8'(1 + (r % 3));  // Gaps of up to two words
      op  = (k < 4) ? op_ldi : opcode_t'(r[10:8]);  // nop .. out
      load_word(pc, make_word(op, r[13:11], r[16:14], r[19:17], r2[15:0], nxt));
      pc = nxt;
    end
    load_word(pc, make_word(op_hlt, 3'd0, 3'd0, 3'd0, 16'h0, pc));
  endtask

  function automatic logic [4:0] test_expect(input logic [2:0] sel, input logic [31:0] st,
                                             input logic zf, input logic [15:0] last_cd);
    case (sel)
      3'd0:    return st[4:0];
      3'd1:    return st[7:3];
      3'd2:    return {zf, st[8], 3'b000};
      3'd3:    return last_cd[4:0];
      default: return 5'd0;
    endcase
  endfunction

  initial begin
    logic [cs_aw-1:0]  addrs [8];
    logic [apb_dw-1:0] st;
    logic              err;
    logic [15:0]       cnt;
    logic [cs_aw-1:0]  hlt_pc;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    sel_testmux = '0;
    errors      = 0;
    checks      = 0;
    repeat (10) @(posedge sysclk);
    #2 rst_n = 1'b1;

    // Idle state after reset
    @(negedge sysclk);
    check_value("reset led", 64'(0), 64'(led));
    check_value("reset cd_valid", 64'(0), 64'(cd_valid));
    apb_xfer(1'b0, stat_addr, 32'h0, st, err);
    check_value("reset status", 64'(0), 64'(st));

    // Random words with both halves read back
    for (int k = 0; k < 8; k++) begin
      addrs[k] = 8'(xorshift32());
      load_word(addrs[k], {xorshift32(), xorshift32()});
    end
    for (int k = 0; k < 8; k++) verify_word(addrs[k], "random readback");

    // Random program with a locked-store probe while it runs
    load_word(8'hff, {xorshift32(), xorshift32()});
    gen_program();
    run_and_check("random program", 1'b1);
    verify_word(8'hff, "locked word readback");

    // Countdown loop with the halt word away from the loop
    cnt    = 16'(3 + (xorshift32() % 6));
    hlt_pc = 8'(8'h40 + (xorshift32() % 64));
    load_word(8'd0, make_word(op_ldi, 3'd1, 3'd0, 3'd0, cnt, 8'd1));
    load_word(8'd1, make_word(op_ldi, 3'd2, 3'd0, 3'd0, 16'd1, 8'd2));
    load_word(8'd2, make_word(op_out, 3'd0, 3'd1, 3'd0, 16'd0, 8'd3));
    load_word(8'd3, make_word(op_sub, 3'd1, 3'd1, 3'd2, 16'd0, 8'd4));
    load_word(8'd4, make_word(op_brz, 3'd0, 3'd0, 3'd0, {8'h00, hlt_pc}, 8'd2));
    load_word(hlt_pc, make_word(op_hlt, 3'd0, 3'd0, 3'd0, 16'd0, 8'd0));
    run_and_check("countdown", 1'b0);
    check_value("countdown loop count", 64'(cnt), 64'(got_q.size()));

    // Test port, status and last output of the halted program
    apb_xfer(1'b0, stat_addr, 32'h0, st, err);
    check_value("halt word address", 64'(hlt_pc), 64'(st[7:0]));
    check_value("halted bit", 64'(1), 64'(st[9]));
    for (int s = 0; s < 8; s++) begin
      @(posedge sysclk); #2;
      sel_testmux = 3'(s);
      @(negedge sysclk);
      check_value($sformatf("testmux %0d", s),
                  64'(test_expect(3'(s), st, model_zero, exp_q[exp_q.size()-1])), 64'(test));
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: wcs_apb_port.sv
// ==========================================================
// APB slave for control store load and readback, run control
// and status registers
// ==========================================================
`timescale 1ns/1ps

module wcs_apb_port
  import nd_cpu_pkg::*;
  import nd_apb_pkg::*;
(
  input  logic              sysclk,
  input  logic              rst_n,
  input  logic [apb_aw-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [apb_dw-1:0] pwdata,
  output logic [apb_dw-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  input  logic [cs_aw-1:0]  upc,
  input  logic              running,
  input  logic              halted,
  output logic              start,   // One cycle, from a run write
  cs_if.host                cs
);

  logic access;   // APB access phase
  logic is_cs;
  logic is_ctrl;
  logic is_stat;
  logic bad;      // Completes with error, no effect
  logic cs_rd;
  logic rd_wait;  // Store read issued, data next cycle
  logic run_q;

  assign access  = psel & penable;
  assign is_cs   = (paddr >= cs_base) && (paddr <= cs_last);
  assign is_ctrl = (paddr == ctrl_addr);
  assign is_stat = (paddr == stat_addr);
  assign bad     = is_cs ? running : !(is_ctrl | is_stat);  // Store locked while running
  assign cs_rd   = access & is_cs & !pwrite & !bad;

  // Store request, word index and half from the byte address
  assign cs.host_addr  = paddr[cs_idx_lsb +: cs_aw];
  assign cs.host_hi    = paddr[cs_hi_bit];
  assign cs.host_wdata = pwdata;
  assign cs.host_we    = access & pwrite & is_cs & !bad;
  assign cs.host_re    = cs_rd & !rd_wait;  // First access cycle only

  assign pready  = !(cs_rd & !rd_wait);  // One wait state on store reads
  assign pslverr = access & bad;
  assign start   = access & pwrite & is_ctrl & pwdata[ctrl_run_bit];

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      rd_wait <= 1'b0;
      run_q   <= 1'b0;
    end else begin
      rd_wait <= cs.host_re;
      if (access & pwrite & is_ctrl) begin
        run_q <= pwdata[ctrl_run_bit];
      end else if (halted) begin
        run_q <= 1'b0;  // Dropped once the program stops
      end
    end
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (is_stat) begin
      prdata = {{(apb_dw - cs_aw - 2){1'b0}}, halted, running, upc};
    end else if (is_ctrl) begin
      prdata[ctrl_run_bit] = run_q;
    end else if (is_cs) begin
      prdata = paddr[cs_hi_bit] ? cs.rdata[mw_width-1:hw_width] : cs.rdata[hw_width-1:0];
    end
  end

endmodule
